// File: include/vga_macros.svh
// VGA raster and sprite size definitions
// Timing for 640 x 480 at a 25 MHz pixel clock, 800 x 525 total raster.

`ifndef VGA_MACROS_SVH
`define VGA_MACROS_SVH

// Horizontal timing in pixels.
`define H_ACTIVE  640
`define H_FP      16
`define H_SYNC    96
`define H_TOTAL   800

// Vertical timing in lines.
`define V_ACTIVE  480
`define V_FP      10
`define V_SYNC    2
`define V_TOTAL   525

// Sprite size in pixels.
`define SPRITE_W  64
`define SPRITE_H  64

`define BLANK_RGB 12'h888 // Grey shown during blanking.

`endif

// File: src/vga_pkg.sv
// VGA types
// Vector types for the raster counters, colours and sprite addressing,
// and the phase encoding used by the timing generator.

package vga_pkg;

    typedef logic [10:0] hcount_t;      // Horizontal pixel counter.
    typedef logic [10:0] vcount_t;      // Vertical line counter.
    typedef logic [11:0] rgb_t;         // 4:4:4 colour.
    typedef logic [11:0] pos_t;         // Sprite position.
    typedef logic [11:0] sprite_addr_t; // Row in the upper 6 bits, column below.

    // Phase of a counter within one raster line or frame.
    typedef enum logic [1:0] {
        PH_ACTIVE,
        PH_FRONT,
        PH_SYNC,
        PH_BACK
    } phase_t;

endpackage

// File: src/vga_timing.sv
// VGA timing generator
// Free-running horizontal and vertical counters for an 800 x 525 raster.
// Sync and blanking levels are decoded from the next count and registered
// so they line up with the counters they belong to.

`timescale 1ns/1ps

`include "vga_macros.svh"

module vga_timing (
    input  logic             clk,
    input  logic             rst,
    output vga_pkg::hcount_t hcount,
    output vga_pkg::vcount_t vcount,
    output logic             hsync,
    output logic             hblnk,
    output logic             vsync,
    output logic             vblnk
);
    import vga_pkg::*;

    hcount_t hcount_nxt;
    vcount_t vcount_nxt;
    phase_t  h_phase;
    phase_t  v_phase;

    // Sorts a count into active, front porch, sync or back porch.
    function automatic phase_t phase_of(input int count, input int active,
                                        input int fp, input int sync);
        if (count < active)
            return PH_ACTIVE;
        else if (count < active + fp)
            return PH_FRONT;
        else if (count < active + fp + sync)
            return PH_SYNC;
        else
            return PH_BACK;
    endfunction

    always_comb begin
        if (hcount == 11'(`H_TOTAL - 1)) begin
            hcount_nxt = '0;
            vcount_nxt = (vcount == 11'(`V_TOTAL - 1)) ? '0 : vcount + 1'b1; // Next line.
        end else begin
            hcount_nxt = hcount + 1'b1;
            vcount_nxt = vcount;
        end
    end

    assign h_phase = phase_of(int'(hcount_nxt), `H_ACTIVE, `H_FP, `H_SYNC);
    assign v_phase = phase_of(int'(vcount_nxt), `V_ACTIVE, `V_FP, `V_SYNC);

    always_ff @(posedge clk) begin
        if (rst) begin
            hcount <= '0;
            vcount <= '0;
            hsync  <= 1'b0;
            hblnk  <= 1'b0;
            vsync  <= 1'b0;
            vblnk  <= 1'b0;
        end else begin
            hcount <= hcount_nxt;
            vcount <= vcount_nxt;
            hsync  <= (h_phase == PH_SYNC);   // Active high sync pulse.
            hblnk  <= (h_phase != PH_ACTIVE);
            vsync  <= (v_phase == PH_SYNC);
            vblnk  <= (v_phase != PH_ACTIVE);
        end
    end

endmodule

// File: src/vga_background.sv
// VGA background stage
// Paints a colour gradient over the visible area and grey during blanking.
// Adds one cycle to the raster group.

`timescale 1ns/1ps

`include "vga_macros.svh"

module vga_background (
    input  logic             clk,
    input  logic             rst,
    input  vga_pkg::hcount_t in_hcount,
    input  vga_pkg::vcount_t in_vcount,
    input  logic             in_hsync,
    input  logic             in_hblnk,
    input  logic             in_vsync,
    input  logic             in_vblnk,
    output vga_pkg::hcount_t out_hcount,
    output vga_pkg::vcount_t out_vcount,
    output logic             out_hsync,
    output logic             out_hblnk,
    output logic             out_vsync,
    output logic             out_vblnk,
    output vga_pkg::rgb_t    out_rgb
);
    import vga_pkg::*;

    rgb_t rgb_nxt;

    // Red follows the line, green follows the column.
    assign rgb_nxt = (in_hblnk || in_vblnk) ? `BLANK_RGB
                                            : {in_vcount[8:5], in_hcount[9:6], 4'h3};

    always_ff @(posedge clk) begin
        if (rst) begin
            out_hcount <= '0;
            out_vcount <= '0;
            out_hsync  <= 1'b0;
            out_hblnk  <= 1'b0;
            out_vsync  <= 1'b0;
            out_vblnk  <= 1'b0;
            out_rgb    <= '0;
        end else begin
            out_hcount <= in_hcount;
            out_vcount <= in_vcount;
            out_hsync  <= in_hsync;
            out_hblnk  <= in_hblnk;
            out_vsync  <= in_vsync;
            out_vblnk  <= in_vblnk;
            out_rgb    <= rgb_nxt;
        end
    end

endmodule

// File: src/signal_delay.sv
// Signal delay line
// Shifts a vector through a chain of clk_del registers, all cleared on reset.

`timescale 1ns/1ps

module signal_delay #(
    parameter int width   = 8,
    parameter int clk_del = 1
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [width-1:0] din,
    output logic [width-1:0] dout
);

    logic [width-1:0] stage [clk_del];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < clk_del; i++) begin
                stage[i] <= '0;
            end
        end else begin
            stage[0] <= din;
            for (int i = 1; i < clk_del; i++) begin
                stage[i] <= stage[i-1]; // Each register passes its value one step on.
            end
        end
    end

    assign dout = stage[clk_del-1];

endmodule

// File: src/sprite_rom.sv
// Sprite ROM
// 4096 x 12 synchronous ROM holding the 64 x 64 emblem: a white frame
// around a checker of coloured and transparent 8 x 8 squares.

`timescale 1ns/1ps

`include "vga_macros.svh"

module sprite_rom (
    input  logic                  clk,
    input  vga_pkg::sprite_addr_t addr,
    output vga_pkg::rgb_t         rgb_pixel
);
    import vga_pkg::*;

    rgb_t rom [`SPRITE_W * `SPRITE_H];

    initial begin
        logic [5:0] r;
        logic [5:0] c;
        for (int row = 0; row < `SPRITE_H; row++) begin
            for (int col = 0; col < `SPRITE_W; col++) begin
                r = 6'(row);
                c = 6'(col);
                if (r == 6'd0 || r == 6'd63 || c == 6'd0 || c == 6'd63)
                    rom[{r, c}] = 12'hfff;                  // White frame.
                else if (r[3] != c[3])
                    rom[{r, c}] = 12'h000;                  // Transparent square.
                else
                    rom[{r, c}] = {r[5:2], c[5:2], 4'h5};
            end
        end
    end

    always_ff @(posedge clk) begin
        rgb_pixel <= rom[addr];
    end

endmodule

// File: src/draw_sprite.sv
// Sprite overlay stage
// Generates the ROM address for the current pixel, optionally mirrored,
// then lays the returned texel over the background. Colour 000 is
// transparent. Adds three cycles to the raster group.

`timescale 1ns/1ps

`include "vga_macros.svh"

module draw_sprite (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  rotate,
    input  logic                  start_game,
    input  logic                  en,
    input  vga_pkg::pos_t         xpos,
    input  vga_pkg::pos_t         ypos,
    input  vga_pkg::rgb_t         rgb_pixel,
    input  vga_pkg::hcount_t      in_hcount,
    input  vga_pkg::vcount_t      in_vcount,
    input  logic                  in_hsync,
    input  logic                  in_hblnk,
    input  logic                  in_vsync,
    input  logic                  in_vblnk,
    input  vga_pkg::rgb_t         in_rgb,
    output vga_pkg::sprite_addr_t sprite_addr,
    output vga_pkg::hcount_t      out_hcount,
    output vga_pkg::vcount_t      out_vcount,
    output logic                  out_hsync,
    output logic                  out_hblnk,
    output logic                  out_vsync,
    output logic                  out_vblnk,
    output vga_pkg::rgb_t         out_rgb
);
    import vga_pkg::*;

    localparam int group_w = $bits(hcount_t) + $bits(vcount_t) + 4 + $bits(rgb_t);

    logic [5:0]   row_ofs;
    logic [5:0]   col_ofs;
    logic [5:0]   col_sel;
    hcount_t      hcount_d;
    vcount_t      vcount_d;
    logic         hsync_d;
    logic         hblnk_d;
    logic         vsync_d;
    logic         vblnk_d;
    rgb_t         rgb_d;
    rgb_t         rgb_nxt;
    logic [12:0]  x_end;
    logic [12:0]  y_end;
    logic         in_box;

    // **************************************************
    // Address generation
    // **************************************************

    assign row_ofs = 6'(in_vcount - ypos);
    assign col_ofs = 6'(in_hcount - xpos);
    assign col_sel = rotate ? 6'(`SPRITE_W - 1) - col_ofs : col_ofs; // Horizontal mirror.

    // Holds the raster group until the ROM data for it arrives.
    signal_delay #(.width(group_w), .clk_del(2)) u_delay (
        .clk,
        .rst,
        .din  ({in_hcount, in_hsync, in_hblnk, in_vcount, in_vsync, in_vblnk, in_rgb}),
        .dout ({hcount_d, hsync_d, hblnk_d, vcount_d, vsync_d, vblnk_d, rgb_d})
    );

    // **************************************************
    // Overlay
    // **************************************************

    assign x_end  = 13'(xpos) + 13'(`SPRITE_W);
    assign y_end  = 13'(ypos) + 13'(`SPRITE_H);
    assign in_box = (12'(hcount_d) >= xpos) && (13'(hcount_d) < x_end) &&
                    (12'(vcount_d) >= ypos) && (13'(vcount_d) < y_end);

    always_comb begin
        if (hblnk_d || vblnk_d)
            rgb_nxt = `BLANK_RGB;
        else if (en && start_game && in_box && (rgb_pixel != '0))
            rgb_nxt = rgb_pixel;                // Opaque texel covers the background.
        else
            rgb_nxt = rgb_d;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sprite_addr <= '0;
            out_hcount  <= '0;
            out_vcount  <= '0;
            out_hsync   <= 1'b0;
            out_hblnk   <= 1'b0;
            out_vsync   <= 1'b0;
            out_vblnk   <= 1'b0;
            out_rgb     <= '0;
        end else begin
            sprite_addr <= {row_ofs, col_sel};
            out_hcount  <= hcount_d;
            out_vcount  <= vcount_d;
            out_hsync   <= hsync_d;
            out_hblnk   <= hblnk_d;
            out_vsync   <= vsync_d;
            out_vblnk   <= vblnk_d;
            out_rgb     <= rgb_nxt;
        end
    end

endmodule

// File: src/vga_top.sv
// VGA sprite overlay top level
// Raster timing feeds the gradient background, which feeds the sprite
// overlay. The sprite stage reads its texels from the emblem ROM.
// Four cycles from the counters to the outputs.

`timescale 1ns/1ps

module vga_top (
    input  logic             clk,
    input  logic             rst,
    input  logic             en,
    input  logic             start_game,
    input  logic             rotate,
    input  vga_pkg::pos_t    xpos,
    input  vga_pkg::pos_t    ypos,
    output vga_pkg::hcount_t hcount,
    output vga_pkg::vcount_t vcount,
    output logic             hsync,
    output logic             hblnk,
    output logic             vsync,
    output logic             vblnk,
    output vga_pkg::rgb_t    rgb
);
    import vga_pkg::*;

    hcount_t      tim_hcount;
    vcount_t      tim_vcount;
    logic         tim_hsync;
    logic         tim_hblnk;
    logic         tim_vsync;
    logic         tim_vblnk;
    hcount_t      bg_hcount;
    vcount_t      bg_vcount;
    logic         bg_hsync;
    logic         bg_hblnk;
    logic         bg_vsync;
    logic         bg_vblnk;
    rgb_t         bg_rgb;
    sprite_addr_t sprite_addr;
    rgb_t         rgb_pixel;

    vga_timing u_timing (
        .clk, .rst,
        .hcount (tim_hcount), .vcount (tim_vcount),
        .hsync  (tim_hsync),  .hblnk  (tim_hblnk),
        .vsync  (tim_vsync),  .vblnk  (tim_vblnk)
    );

    vga_background u_background (
        .clk, .rst,
        .in_hcount  (tim_hcount), .in_vcount  (tim_vcount),
        .in_hsync   (tim_hsync),  .in_hblnk   (tim_hblnk),
        .in_vsync   (tim_vsync),  .in_vblnk   (tim_vblnk),
        .out_hcount (bg_hcount),  .out_vcount (bg_vcount),
        .out_hsync  (bg_hsync),   .out_hblnk  (bg_hblnk),
        .out_vsync  (bg_vsync),   .out_vblnk  (bg_vblnk),
        .out_rgb    (bg_rgb)
    );

    draw_sprite u_draw_sprite (
        .clk, .rst, .rotate, .start_game, .en, .xpos, .ypos, .rgb_pixel,
        .in_hcount  (bg_hcount), .in_vcount (bg_vcount),
        .in_hsync   (bg_hsync),  .in_hblnk  (bg_hblnk),
        .in_vsync   (bg_vsync),  .in_vblnk  (bg_vblnk),
        .in_rgb     (bg_rgb),
        .sprite_addr,
        .out_hcount (hcount),    .out_vcount (vcount),
        .out_hsync  (hsync),     .out_hblnk  (hblnk),
        .out_vsync  (vsync),     .out_vblnk  (vblnk),
        .out_rgb    (rgb)
    );

    sprite_rom u_sprite_rom (
        .clk,
        .addr      (sprite_addr),
        .rgb_pixel (rgb_pixel)
    );

endmodule

// File: tests/vga_top_props.sv
// VGA output properties
// Concurrent assertions on the raster outputs of the top level, bound
// into every instance of it.

`timescale 1ns/1ps

`include "vga_macros.svh"

module vga_top_props (
    input logic             clk,
    input logic             rst,
    input vga_pkg::hcount_t hcount,
    input vga_pkg::vcount_t vcount,
    input logic             hblnk,
    input logic             vsync,
    input logic             vblnk,
    input vga_pkg::rgb_t    rgb
);

    hblnk_range: assert property (@(posedge clk) disable iff (rst)
        hblnk |-> hcount >= 11'(`H_ACTIVE))
        else $error("hblnk high at hcount %0d", hcount);

    // The vertical sync pulse covers two lines after the front porch.
    vsync_lines: assert property (@(posedge clk) disable iff (rst)
        vsync |-> (vcount == 11'(`V_ACTIVE + `V_FP) || vcount == 11'(`V_ACTIVE + `V_FP + 1)))
        else $error("vsync high on line %0d", vcount);

    blank_grey: assert property (@(posedge clk) disable iff (rst)
        (hblnk || vblnk) |-> rgb == `BLANK_RGB)
        else $error("rgb %h during blanking", rgb);

endmodule

bind vga_top vga_top_props props0 (
    .clk    (clk),
    .rst    (rst),
    .hcount (hcount),
    .vcount (vcount),
    .hblnk  (hblnk),
    .vsync  (vsync),
    .vblnk  (vblnk),
    .rgb    (rgb)
);

// File: tests/vga_top_tb.sv
// VGA sprite overlay testbench
// Applies one stimulus line per frame at line 500, then checks every output
// pixel of the following frame against a model of the raster, the gradient
// and the emblem, and counts the sprite pixels of each frame.

`timescale 1ns/1ps

`include "vga_macros.svh"

module vga_top_tb;
    import vga_pkg::*;

    localparam int frame_cycles = `H_TOTAL * `V_TOTAL;
    localparam int max_cycles   = 7 * frame_cycles;  // Six checked frames and the start-up frame.
    localparam int apply_line   = 500;               // Deep in vertical blanking.

    logic    clk;
    logic    rst;
    logic    en;
    logic    start_game;
    logic    rotate;
    pos_t    xpos;
    pos_t    ypos;
    hcount_t hcount;
    vcount_t vcount;
    logic    hsync;
    logic    hblnk;
    logic    vsync;
    logic    vblnk;
    rgb_t    rgb;

    int          q_en[$];
    int          q_start[$];
    int          q_rot[$];
    int          q_x[$];
    int          q_y[$];
    int          q_cnt[$];
    int          cur_en;
    int          cur_start;
    int          cur_rot;
    int          cur_x;
    int          cur_y;
    int          prev_h;
    int          prev_v;
    int          sprite_px;
    int          cycles = 0;
    logic [15:0] lfsr_state = 16'd49640;

    vga_top dut0 (
        .clk, .rst, .en, .start_game, .rotate, .xpos, .ypos,
        .hcount, .vcount, .hsync, .hblnk, .vsync, .vblnk, .rgb
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // **************************************************
    // Reference model
    // **************************************************

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    task automatic random_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            value = (value << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_next(lfsr_state);            // One step per bit taken.
        end
    endtask

    function automatic rgb_t background_colour(input int h, input int v);
        logic [10:0] hb;
        logic [10:0] vb;
        hb = 11'(h);
        vb = 11'(v);
        if (h >= `H_ACTIVE || v >= `V_ACTIVE)
            return `BLANK_RGB;
        return {vb[8:5], hb[9:6], 4'h3};
    endfunction

    function automatic rgb_t emblem_texel(input int row, input int col);
        logic [5:0] r;
        logic [5:0] c;
        r = 6'(row);
        c = 6'(col);
        if (row == 0 || row == `SPRITE_H - 1 || col == 0 || col == `SPRITE_W - 1)
            return 12'hfff;                                // Frame of the emblem.
        if (r[3] != c[3])
            return 12'h000;
        return {r[5:2], c[5:2], 4'h5};
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped after a failed check");
    endtask

    // **************************************************
    // Stimulus and checks
    // **************************************************

    task automatic read_stimulus();
        int    fd;
        int    n;
        string line;
        int    v[6];
        fd = $fopen("tests/vga_stimulus.txt", "r");
        if (fd == 0) begin
            stop_run("cannot open the stimulus file tests/vga_stimulus.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 0 && line[0] != "#") begin
                    n = $sscanf(line, "%d %d %d %d %d %d", v[0], v[1], v[2], v[3], v[4], v[5]);
                    if (n == 6) begin
                        q_en.push_back(v[0]);
                        q_start.push_back(v[1]);
                        q_rot.push_back(v[2]);
                        q_x.push_back(v[3]);
                        q_y.push_back(v[4]);
                        q_cnt.push_back(v[5]);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic apply_frame(input int idx);
        int rx;
        int ry;
        cur_en    = q_en[idx];
        cur_start = q_start[idx];
        cur_rot   = q_rot[idx];
        cur_x     = q_x[idx];
        cur_y     = q_y[idx];
        if (cur_x == 4095 && cur_y == 4095) begin
            random_bits(9, rx);                            // Keeps the whole sprite on screen.
            random_bits(8, ry);
            cur_x = rx;
            cur_y = ry;
        end
        en         <= (cur_en != 0);
        start_game <= (cur_start != 0);
        rotate     <= (cur_rot != 0);
        xpos       <= 12'(cur_x);
        ypos       <= 12'(cur_y);
        $display("frame %0d: en %0d start %0d rotate %0d at (%0d,%0d)",
                 idx, cur_en, cur_start, cur_rot, cur_x, cur_y);
    endtask

    task automatic check_outputs();
        int   h;
        int   v;
        int   col;
        int   exp_h;
        int   exp_v;
        logic hs;
        logic vs;
        rgb_t exp_rgb;
        rgb_t texel;
        h = int'(hcount);
        v = int'(vcount);
        exp_h = (prev_h == `H_TOTAL - 1) ? 0 : prev_h + 1;
        exp_v = prev_v;
        if (prev_h == `H_TOTAL - 1)
            exp_v = (prev_v == `V_TOTAL - 1) ? 0 : prev_v + 1;
        assert (h == exp_h && v == exp_v) else
            stop_run($sformatf("** Error at %0t: raster at (%0d,%0d), expected (%0d,%0d)",
                               $time, h, v, exp_h, exp_v));
        prev_h = h;
        prev_v = v;
        hs = (h >= `H_ACTIVE + `H_FP) && (h < `H_ACTIVE + `H_FP + `H_SYNC);
        vs = (v >= `V_ACTIVE + `V_FP) && (v < `V_ACTIVE + `V_FP + `V_SYNC);
        assert (hsync == hs && vsync == vs) else
            stop_run($sformatf("** Error at %0t: sync levels %b%b at (%0d,%0d)",
                               $time, hsync, vsync, h, v));
        assert (hblnk == (h >= `H_ACTIVE) && vblnk == (v >= `V_ACTIVE)) else
            stop_run($sformatf("** Error at %0t: blank levels %b%b at (%0d,%0d)",
                               $time, hblnk, vblnk, h, v));
        exp_rgb = background_colour(h, v);
        if (h < `H_ACTIVE && v < `V_ACTIVE && cur_en != 0 && cur_start != 0 &&
            h >= cur_x && h < cur_x + `SPRITE_W && v >= cur_y && v < cur_y + `SPRITE_H) begin
            col = h - cur_x;
            if (cur_rot != 0)
                col = `SPRITE_W - 1 - col;                 // Mirrored column.
            texel = emblem_texel(v - cur_y, col);
            if (texel != 12'h000)
                exp_rgb = texel;
        end
        assert (rgb == exp_rgb) else
            stop_run($sformatf("** Error at %0t: rgb %h at (%0d,%0d), expected %h",
                               $time, rgb, h, v, exp_rgb));
        if (h < `H_ACTIVE && v < `V_ACTIVE && rgb != background_colour(h, v))
            sprite_px++;                                   // Visible pixel drawn by the sprite.
    endtask

    initial begin
        int   applied;
        int   frames_checked;
        logic started;
        logic done;
        rst        = 1'b1;
        en         = 1'b0;
        start_game = 1'b0;
        rotate     = 1'b0;
        xpos       = '0;
        ypos       = '0;
        cur_en     = 0;
        cur_start  = 0;
        cur_rot    = 0;
        cur_x      = 0;
        cur_y      = 0;
        sprite_px  = 0;
        read_stimulus();
        repeat (3) @(posedge clk);
        @(negedge clk);
        assert (hcount == '0 && vcount == '0 && !hsync && !hblnk && !vsync && !vblnk &&
                rgb == '0) else
            stop_run("outputs are not all zero while reset is held");
        @(posedge clk);
        rst <= 1'b0;
        applied        = -1;
        frames_checked = 0;
        started        = 1'b0;
        done           = 1'b0;
        while (!done) begin
            @(negedge clk);
            if (started)
                check_outputs();
            if (int'(vcount) == apply_line && int'(hcount) == 0) begin
                if (applied >= 0) begin
                    assert (sprite_px == q_cnt[applied]) else
                        stop_run($sformatf(
                            "** Error at %0t: frame %0d has %0d sprite pixels, expected %0d",
                            $time, applied, sprite_px, q_cnt[applied]));
                    frames_checked++;
                end
                if (!started) begin
                    prev_h  = 0;
                    prev_v  = apply_line;
                    started = 1'b1;
                end
                sprite_px = 0;
                applied++;
                if (applied < q_en.size()) begin
                    @(posedge clk);
                    apply_frame(applied);
                end else begin
                    done = 1'b1;
                end
            end
        end
        if (frames_checked == q_en.size() && frames_checked > 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            stop_run("the stimulus file held no frame to check");
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= max_cycles)
            stop_run($sformatf("timeout: %0d cycles passed before all frames were checked",
                               cycles));
    end

endmodule

// File: tests/vga_stimulus.txt
# en start_game rotate xpos ypos sprite_pixels, all decimal, one line per frame
# A position of 4095 4095 asks for a random position that keeps the sprite on screen.
0 1 0 100 100 0
1 1 0 200 150 2174
1 1 1 300 200 2174
1 0 0 50 60 0
1 1 1 608 448 543
1 1 0 4095 4095 2174

// File: vlog.f
+incdir+include
src/vga_pkg.sv
src/vga_timing.sv
src/vga_background.sv
src/signal_delay.sv
src/sprite_rom.sv
src/draw_sprite.sv
src/vga_top.sv
tests/vga_top_props.sv
tests/vga_top_tb.sv

// File: run.sh
#!/bin/sh
# Builds the VGA sprite overlay testbench with Verilator and runs it.
# Exits non-zero when the build fails, the run fails or the log reports failure.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f vlog.f --top-module vga_top_tb -o vga_top_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/vga_top_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "TESTS FAILED" "$LOG"; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation ended with status $status"
    exit 1
fi
exit 0
